// ==== Bender.yml ====
package:
  name: dual_exec

sources:
  - files:
      - src/exec_pkg.sv
      - src/stage_bus.sv
      - src/reg_file.sv
      - src/forward.sv
      - src/alu.sv
      - src/exec_pipe.sv
      - src/credit_counter.sv
      - src/pipe_ctrl.sv
      - src/dual_exec_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_dual_exec.sv

// ==== dual_exec_top.f ====
+incdir+tests
src/exec_pkg.sv
src/stage_bus.sv
src/reg_file.sv
src/forward.sv
src/alu.sv
src/exec_pipe.sv
src/credit_counter.sv
src/pipe_ctrl.sv
src/dual_exec_top.sv
tests/tb_dual_exec.sv

// ==== src/alu.sv ====
// Single-cycle integer ALU for one issue lane.
// Pure combinational; result is captured by the exe1 stage register.
`timescale 1ns/1ps

module alu (
    input  exec_pkg::alu_op_e         op,
    input  logic [exec_pkg::XLEN-1:0] a,
    input  logic [exec_pkg::XLEN-1:0] b,
    input  logic [19:0]               imm,
    output logic [exec_pkg::XLEN-1:0] result
);
    import exec_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // shifts use low 5 bits only

    always_comb begin
        unique case (op)
            OP_ADD: result = a + b;
            OP_SUB: result = a - b;
            OP_AND: result = a & b;
            OP_OR:  result = a | b;
            OP_XOR: result = a ^ b;
            OP_SLL: result = a << shamt;
            OP_SRL: result = a >> shamt;  // logical
            OP_SLT: begin
                if ($signed(a) < $signed(b))
                    result = XLEN'(1);
                else
                    result = '0;
            end
            OP_LUI: result = {imm, 12'b0};
            default: result = '0;
        endcase
    end

endmodule

// ==== src/credit_counter.sv ====
// Output credit count, preset to the downstream grant at reset.
// One credit spent per retired pair, one returned per credit_return pulse.
`timescale 1ns/1ps

module credit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic credit_return,
    input  logic consume,
    output logic credit_avail
);
    import exec_pkg::*;

    logic [CREDIT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= CREDIT_W'(CREDIT_MAX);
        end else begin
            unique case ({credit_return, consume})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none, or return cancels spend
            endcase
        end
    end

    assign credit_avail = (count != '0);

endmodule

// ==== src/dual_exec_top.sv ====
// Top level of the dual-issue execute slice with plain ports.
// valid/ready on the issue side, credit-based flow control on the result side.
`timescale 1ns/1ps

module dual_exec_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  exec_pkg::alu_op_e           op0,
    input  logic [exec_pkg::REG_AW-1:0] rj0,
    input  logic [exec_pkg::REG_AW-1:0] rk0,
    input  logic [exec_pkg::REG_AW-1:0] rd0,
    input  logic [19:0]                 imm0,
    input  logic                        we0,
    input  exec_pkg::alu_op_e           op1,
    input  logic [exec_pkg::REG_AW-1:0] rj1,
    input  logic [exec_pkg::REG_AW-1:0] rk1,
    input  logic [exec_pkg::REG_AW-1:0] rd1,
    input  logic [19:0]                 imm1,
    input  logic                        we1,
    output logic                        out_valid,
    output logic                        out_we0,
    output logic [exec_pkg::REG_AW-1:0] out_rd0,
    output logic [exec_pkg::XLEN-1:0]   out_data0,
    output logic                        out_we1,
    output logic [exec_pkg::REG_AW-1:0] out_rd1,
    output logic [exec_pkg::XLEN-1:0]   out_data1,
    input  logic                        credit_return,
    output logic                        busy
);

    logic       advance;
    logic       retire;
    logic       credit_avail;
    logic [2:0] occupancy;

    assign in_ready = advance;

    exec_pipe u_exec_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .in_load   (in_valid & advance),  // accept edge
        .op0       (op0),
        .rj0       (rj0),
        .rk0       (rk0),
        .rd0       (rd0),
        .imm0      (imm0),
        .we0       (we0),
        .op1       (op1),
        .rj1       (rj1),
        .rk1       (rk1),
        .rd1       (rd1),
        .imm1      (imm1),
        .we1       (we1),
        .occupancy (occupancy),
        .out_valid (out_valid),
        .out_we0   (out_we0),
        .out_rd0   (out_rd0),
        .out_data0 (out_data0),
        .out_we1   (out_we1),
        .out_rd1   (out_rd1),
        .out_data1 (out_data1),
        .retire    (retire)
    );

    pipe_ctrl u_pipe_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .occupancy    (occupancy),
        .out_valid    (out_valid),
        .credit_avail (credit_avail),
        .advance      (advance),
        .retire       (retire),
        .busy         (busy)
    );

    credit_counter u_credit_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .credit_return (credit_return),
        .consume       (retire),
        .credit_avail  (credit_avail)
    );

endmodule

// ==== src/exec_pipe.sv ====
// rf / exe1 / exe2 stage registers of the dual-issue slice.
// Reads operands in rf, computes in exe1, writes back from exe2 on retire.
`timescale 1ns/1ps

module exec_pipe (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        advance,
    input  logic                        in_load,
    input  exec_pkg::alu_op_e           op0,
    input  logic [exec_pkg::REG_AW-1:0] rj0,
    input  logic [exec_pkg::REG_AW-1:0] rk0,
    input  logic [exec_pkg::REG_AW-1:0] rd0,
    input  logic [19:0]                 imm0,
    input  logic                        we0,
    input  exec_pkg::alu_op_e           op1,
    input  logic [exec_pkg::REG_AW-1:0] rj1,
    input  logic [exec_pkg::REG_AW-1:0] rk1,
    input  logic [exec_pkg::REG_AW-1:0] rd1,
    input  logic [19:0]                 imm1,
    input  logic                        we1,
    output logic [2:0]                  occupancy,
    output logic                        out_valid,
    output logic                        out_we0,
    output logic [exec_pkg::REG_AW-1:0] out_rd0,
    output logic [exec_pkg::XLEN-1:0]   out_data0,
    output logic                        out_we1,
    output logic [exec_pkg::REG_AW-1:0] out_rd1,
    output logic [exec_pkg::XLEN-1:0]   out_data1,
    input  logic                        retire
);
    import exec_pkg::*;

    // rf stage
    logic              rf_valid;
    alu_op_e           rf_op0, rf_op1;
    logic [REG_AW-1:0] rf_rj0, rf_rk0, rf_rd0, rf_rj1, rf_rk1, rf_rd1;
    logic [19:0]       rf_imm0, rf_imm1;
    logic              rf_we0, rf_we1;
    // exe1 / exe2 stages
    logic              e1_valid, e2_valid;
    logic              e1_we0, e1_we1, e2_we0, e2_we1;
    logic [REG_AW-1:0] e1_rd0, e1_rd1, e2_rd0, e2_rd1;
    logic [XLEN-1:0]   e1_data0, e1_data1, e2_data0, e2_data1;

    logic [XLEN-1:0] rdata0, rdata1, rdata2, rdata3;
    logic [XLEN-1:0] sr00, sr01, sr10, sr11;
    logic [XLEN-1:0] alu_res0, alu_res1;

    stage_bus exe1_bus ();
    stage_bus exe2_bus ();

    // stage valids, frozen when advance is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rf_valid <= 1'b0;
            e1_valid <= 1'b0;
            e2_valid <= 1'b0;
        end else if (advance) begin
            rf_valid <= in_load;
            e1_valid <= rf_valid;
            e2_valid <= e1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_load) begin
            rf_op0  <= op0;
            rf_rj0  <= rj0;
            rf_rk0  <= rk0;
            rf_rd0  <= rd0;
            rf_imm0 <= imm0;
            rf_we0  <= we0;
            rf_op1  <= op1;
            rf_rj1  <= rj1;
            rf_rk1  <= rk1;
            rf_rd1  <= rd1;
            rf_imm1 <= imm1;
            rf_we1  <= we1;
        end
        if (advance) begin
            e1_we0   <= rf_we0;
            e1_rd0   <= rf_rd0;
            e1_data0 <= alu_res0;
            e1_we1   <= rf_we1;
            e1_rd1   <= rf_rd1;
            e1_data1 <= alu_res1;
            e2_we0   <= e1_we0;
            e2_rd0   <= e1_rd0;
            e2_data0 <= e1_data0;
            e2_we1   <= e1_we1;
            e2_rd1   <= e1_rd1;
            e2_data1 <= e1_data1;
        end
    end

    assign exe1_bus.en0   = e1_valid & e1_we0;
    assign exe1_bus.rd0   = e1_rd0;
    assign exe1_bus.data0 = e1_data0;
    assign exe1_bus.en1   = e1_valid & e1_we1;
    assign exe1_bus.rd1   = e1_rd1;
    assign exe1_bus.data1 = e1_data1;

    assign exe2_bus.en0   = e2_valid & e2_we0;
    assign exe2_bus.rd0   = e2_rd0;
    assign exe2_bus.data0 = e2_data0;
    assign exe2_bus.en1   = e2_valid & e2_we1;
    assign exe2_bus.rd1   = e2_rd1;
    assign exe2_bus.data1 = e2_data1;

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr0 (rf_rj0),
        .raddr1 (rf_rk0),
        .raddr2 (rf_rj1),
        .raddr3 (rf_rk1),
        .rdata0 (rdata0),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .rdata3 (rdata3),
        .we0    (retire & exe2_bus.en0),
        .waddr0 (e2_rd0),
        .wdata0 (e2_data0),
        .we1    (retire & exe2_bus.en1),
        .waddr1 (e2_rd1),
        .wdata1 (e2_data1)
    );

    forward u_forward (
        .eu0_rj  (rf_rj0),
        .eu0_rk  (rf_rk0),
        .eu1_rj  (rf_rj1),
        .eu1_rk  (rf_rk1),
        .data00  (rdata0),
        .data01  (rdata1),
        .data10  (rdata2),
        .data11  (rdata3),
        .exe1    (exe1_bus),
        .exe2    (exe2_bus),
        .eu0_sr0 (sr00),
        .eu0_sr1 (sr01),
        .eu1_sr0 (sr10),
        .eu1_sr1 (sr11)
    );

    alu u_alu0 (
        .op     (rf_op0),
        .a      (sr00),
        .b      (sr01),
        .imm    (rf_imm0),
        .result (alu_res0)
    );

    alu u_alu1 (
        .op     (rf_op1),
        .a      (sr10),
        .b      (sr11),
        .imm    (rf_imm1),
        .result (alu_res1)
    );

    assign occupancy = {e2_valid, e1_valid, rf_valid};
    assign out_valid = e2_valid;
    assign out_we0   = exe2_bus.en0;
    assign out_rd0   = e2_rd0;
    assign out_data0 = e2_data0;
    assign out_we1   = exe2_bus.en1;
    assign out_rd1   = e2_rd1;
    assign out_data1 = e2_data1;

endmodule

// ==== src/exec_pkg.sv ====
// Shared widths, credit depth and enums for the dual-issue execute slice.
// Imported by every RTL block that needs a data width or an opcode.
package exec_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;   // 32 architectural registers

    // credits granted by downstream at reset
    localparam int CREDIT_MAX = 4;
    localparam int CREDIT_W   = 3;  // holds 0..CREDIT_MAX

    // lane opcodes
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SLT,  // signed compare, yields 0 or 1
        OP_LUI   // imm << 12
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_STALL
    } pipe_state_e;

endpackage

// ==== src/forward.sv ====
// Operand bypass for the four rf-stage sources of a pair.
// Picks the youngest in-flight writer from exe1/exe2, else the register file.
`timescale 1ns/1ps

module forward (
    input  logic [exec_pkg::REG_AW-1:0] eu0_rj,
    input  logic [exec_pkg::REG_AW-1:0] eu0_rk,
    input  logic [exec_pkg::REG_AW-1:0] eu1_rj,
    input  logic [exec_pkg::REG_AW-1:0] eu1_rk,
    // register file values
    input  logic [exec_pkg::XLEN-1:0]   data00,
    input  logic [exec_pkg::XLEN-1:0]   data01,
    input  logic [exec_pkg::XLEN-1:0]   data10,
    input  logic [exec_pkg::XLEN-1:0]   data11,
    stage_bus.sink                      exe1,
    stage_bus.sink                      exe2,
    // to the ALU lanes
    output logic [exec_pkg::XLEN-1:0]   eu0_sr0,
    output logic [exec_pkg::XLEN-1:0]   eu0_sr1,
    output logic [exec_pkg::XLEN-1:0]   eu1_sr0,
    output logic [exec_pkg::XLEN-1:0]   eu1_sr1
);
    import exec_pkg::*;

    // priority: exe1 lane1, exe1 lane0, exe2 lane1, exe2 lane0, regfile
    function automatic logic [XLEN-1:0] bypass(
        input logic [REG_AW-1:0] src,
        input logic [XLEN-1:0]   rf_val
    );
        if (src == '0)
            return rf_val;           // r0 never forwarded
        else if (exe1.en1 && src == exe1.rd1)
            return exe1.data1;
        else if (exe1.en0 && src == exe1.rd0)
            return exe1.data0;
        else if (exe2.en1 && src == exe2.rd1)
            return exe2.data1;
        else if (exe2.en0 && src == exe2.rd0)
            return exe2.data0;
        else
            return rf_val;
    endfunction

    // the pair in rf never bypasses to itself, so lane 1 sees old lane 0 rd
    always_comb begin
        eu0_sr0 = bypass(eu0_rj, data00);
        eu0_sr1 = bypass(eu0_rk, data01);
        eu1_sr0 = bypass(eu1_rj, data10);
        eu1_sr1 = bypass(eu1_rk, data11);
    end

endmodule

// ==== src/pipe_ctrl.sv ====
// Pipeline control: advance/freeze decision, retire pulse and busy state.
// Freezes the whole pipe while exe2 holds a pair and no credit is left.
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] occupancy,
    input  logic       out_valid,
    input  logic       credit_avail,
    output logic       advance,
    output logic       retire,
    output logic       busy
);
    import exec_pkg::*;

    pipe_state_e state, state_nxt;
    logic        stall;

    assign stall   = out_valid & ~credit_avail;
    assign advance = ~stall;
    assign retire  = out_valid & credit_avail;
    assign busy    = (state != ST_IDLE);

    always_comb begin
        state_nxt = state;
        unique case (state)
            ST_IDLE: begin
                if (stall)
                    state_nxt = ST_STALL;
                else if (occupancy != '0)
                    state_nxt = ST_RUN;
            end
            ST_RUN: begin
                if (stall)
                    state_nxt = ST_STALL;
                else if (occupancy == '0)
                    state_nxt = ST_IDLE;  // drained
            end
            ST_STALL: begin
                if (!stall)
                    state_nxt = ST_RUN;   // credit back
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

endmodule

// ==== src/reg_file.sv ====
// 32 x XLEN integer register file, four async read ports and two write ports.
// r0 is hardwired to zero; port 1 wins on a same-address write.
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [exec_pkg::REG_AW-1:0] raddr0,
    input  logic [exec_pkg::REG_AW-1:0] raddr1,
    input  logic [exec_pkg::REG_AW-1:0] raddr2,
    input  logic [exec_pkg::REG_AW-1:0] raddr3,
    output logic [exec_pkg::XLEN-1:0]   rdata0,
    output logic [exec_pkg::XLEN-1:0]   rdata1,
    output logic [exec_pkg::XLEN-1:0]   rdata2,
    output logic [exec_pkg::XLEN-1:0]   rdata3,
    input  logic                        we0,
    input  logic [exec_pkg::REG_AW-1:0] waddr0,
    input  logic [exec_pkg::XLEN-1:0]   wdata0,
    input  logic                        we1,
    input  logic [exec_pkg::REG_AW-1:0] waddr1,
    input  logic [exec_pkg::XLEN-1:0]   wdata1
);
    import exec_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AW];

    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];
    assign rdata3 = regs[raddr3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0 && waddr0 != '0)
                regs[waddr0] <= wdata0;
            if (we1 && waddr1 != '0)
                regs[waddr1] <= wdata1;  // later write, lane 1 wins
        end
    end

endmodule

// ==== src/stage_bus.sv ====
// Write-back view of one stage register (both lanes) for the bypass network.
// The pipe drives it from exe1 or exe2, the forwarding unit reads it.
`timescale 1ns/1ps

interface stage_bus;
    import exec_pkg::*;

    logic              en0;   // lane 0 valid and writing
    logic [REG_AW-1:0] rd0;
    logic [XLEN-1:0]   data0;
    logic              en1;
    logic [REG_AW-1:0] rd1;
    logic [XLEN-1:0]   data1;

    modport src (
        output en0, rd0, data0,
        output en1, rd1, data1
    );

    modport sink (
        input en0, rd0, data0,
        input en1, rd1, data1
    );

endinterface

// ==== tests/tb_ref_model.svh ====
// Reference ALU, architectural register model and typed compare tasks.
// Included inside the testbench module body after err_count and EXP_W.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [XLEN-1:0] arch_regs [2**REG_AW];

function automatic void clear_model();
    for (int r = 0; r < 2**REG_AW; r++)
        arch_regs[r] = '0;
endfunction

function automatic logic [XLEN-1:0] ref_alu(input alu_op_e op, input logic [XLEN-1:0] a, b,
                                            input logic [19:0] imm);
    logic [XLEN-1:0] r;
    case (op)
        OP_ADD: r = a + b;
        OP_SUB: r = a - b;
        OP_AND: r = a & b;
        OP_OR:  r = a | b;
        OP_XOR: r = a ^ b;
        OP_SLL: r = a << b[4:0];
        OP_SRL: r = a >> b[4:0];
        // signs differ: a is less exactly when it is negative
        OP_SLT: r = (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
        OP_LUI: r = XLEN'(imm) << 12;
        default: r = '0;
    endcase
    return r;
endfunction

// both lanes read before either writes, lane 1 written last
function automatic logic [EXP_W-1:0] predict_pair(
    input alu_op_e o0, input logic [REG_AW-1:0] j0, k0, d0, input logic [19:0] i0,
    input logic w0,
    input alu_op_e o1, input logic [REG_AW-1:0] j1, k1, d1, input logic [19:0] i1,
    input logic w1
);
    logic [XLEN-1:0] res0;
    logic [XLEN-1:0] res1;
    res0 = ref_alu(o0, arch_regs[j0], arch_regs[k0], i0);
    res1 = ref_alu(o1, arch_regs[j1], arch_regs[k1], i1);
    if (w0 && d0 != '0)
        arch_regs[d0] = res0;
    if (w1 && d1 != '0)
        arch_regs[d1] = res1;
    return {w0, d0, res0, w1, d1, res1};
endfunction

task automatic check_data(input string name, input logic [XLEN-1:0] got, exp);
    if (got !== exp) begin
        $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
        err_count++;
    end
endtask

task automatic check_reg(input string name, input logic [REG_AW-1:0] got, exp);
    if (got !== exp) begin
        $display("error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        err_count++;
    end
endtask

task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
        $display("error at %0t: %s = %b, expected %b", $time, name, got, exp);
        err_count++;
    end
endtask

`endif

// ==== tests/tb_dual_exec.sv ====
// Testbench for the dual-issue execute slice with directed and random pairs
// checked in order against a register-level reference model.
`timescale 1ns/1ps

module tb_dual_exec;
    import exec_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int N_DIRECTED  = 40;
    localparam int N_RANDOM    = 200;
    localparam int TIMEOUT_CYC = (N_DIRECTED + N_RANDOM) * 20 + 200;
    localparam int HALF_W      = 1 + REG_AW + XLEN;
    localparam int EXP_W       = 2 * HALF_W;

    logic clk, rst_n, in_valid, in_ready, credit_return, busy;
    alu_op_e op0, op1;
    logic [REG_AW-1:0] rj0, rk0, rd0, rj1, rk1, rd1;
    logic [19:0] imm0, imm1;
    logic we0, we1;
    logic out_valid, out_we0, out_we1;
    logic [REG_AW-1:0] out_rd0, out_rd1;
    logic [XLEN-1:0] out_data0, out_data1;

    int err_count, checked, spent, returned, cyc, ret_mode;  // ret_mode 0 hold, 1 fast, 2 gaps
    int test_no, err_base;
    bit gap_pat [256];
    logic [EXP_W-1:0] exp_q [$];

    `include "tb_ref_model.svh"

    dual_exec_top dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin : watchdog
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("Simulation FAILED");
        $finish;
    end

    // downstream model deciding retire from its own credit count
    initial begin : credit_and_compare
        logic do_ret;
        logic [EXP_W-1:0] e;
        credit_return = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                do_ret = (spent > returned) &&
                         (ret_mode == 1 || (ret_mode == 2 && gap_pat[cyc % 256]));
                if (out_valid && (CREDIT_MAX - spent + returned) > 0) begin
                    if (exp_q.size() == 0) begin
                        $display("a pair retired at %0t with none expected", $time);
                        err_count++;
                    end else begin
                        e = exp_q.pop_front();
                        check_bit("out_we0", out_we0, e[2*HALF_W-1]);
                        check_reg("out_rd0", out_rd0, e[2*HALF_W-2 -: REG_AW]);
                        check_data("out_data0", out_data0, e[HALF_W +: XLEN]);
                        check_bit("out_we1", out_we1, e[HALF_W-1]);
                        check_reg("out_rd1", out_rd1, e[HALF_W-2 -: REG_AW]);
                        check_data("out_data1", out_data1, e[0 +: XLEN]);
                        checked++;
                    end
                    spent++;
                end
                if (do_ret)
                    returned++;
                credit_return = do_ret;
                cyc++;
            end
        end
    end

    // starts on a falling edge and returns on the one after acceptance
    task automatic send_pair(
        input alu_op_e o0, input logic [REG_AW-1:0] j0, k0, d0, input logic [19:0] i0,
        input logic w0,
        input alu_op_e o1, input logic [REG_AW-1:0] j1, k1, d1, input logic [19:0] i1,
        input logic w1
    );
        op0 = o0;
        rj0 = j0;
        rk0 = k0;
        rd0 = d0;
        imm0 = i0;
        we0 = w0;
        op1 = o1;
        rj1 = j1;
        rk1 = k1;
        rd1 = d1;
        imm1 = i1;
        we1 = w1;
        in_valid = 1'b1;
        while (!in_ready)
            @(negedge clk);
        exp_q.push_back(predict_pair(o0, j0, k0, d0, i0, w0, o1, j1, k1, d1, i1, w1));
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0)
            @(negedge clk);
        while (busy && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            $display("busy still high %0d cycles after the last result", waited);
            err_count++;
        end
    endtask

    task automatic test_begin();
        test_no++;
        err_base = err_count;
    endtask

    task automatic test_end(input string name);
        $display("test %0d %s: %0d errors", test_no, name, err_count - err_base);
    endtask

    initial begin : main
        int i;
        int d;
        int n;
        alu_op_e ro0, ro1;
        logic [REG_AW-1:0] ra0, rb0, rc0, ra1, rb1, rc1;
        logic [19:0] ri0, ri1;
        logic rw0, rw1;
        void'($urandom(32'h6bb30326));
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        op0 = OP_ADD;
        op1 = OP_ADD;
        {rj0, rk0, rd0, rj1, rk1, rd1} = '0;
        {imm0, imm1, we0, we1} = '0;
        {err_count, checked, spent, returned, cyc, test_no, err_base} = '0;
        ret_mode = 1;
        for (i = 0; i < 256; i++)
            gap_pat[i] = ($urandom_range(0, 2) == 0);
        clear_model();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        test_begin();
        // empty pipe after reset
        check_bit("in_ready", in_ready, 1'b1);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("busy", busy, 1'b0);
        send_pair(OP_LUI, 5'd0, 5'd0, 5'd1, 20'h12345, 1'b1,
                  OP_LUI, 5'd0, 5'd0, 5'd2, 20'hfedcb, 1'b1);
        send_pair(OP_LUI, 5'd0, 5'd0, 5'd3, 20'h00003, 1'b1,
                  OP_LUI, 5'd0, 5'd0, 5'd9, 20'h80000, 1'b1);
        idle(4);
        send_pair(OP_SLT, 5'd2, 5'd1, 5'd4, 20'h0, 1'b1, OP_SLT, 5'd1, 5'd2, 5'd5, 20'h0, 1'b1);
        send_pair(OP_SUB, 5'd0, 5'd1, 5'd6, 20'h0, 1'b1, OP_ADD, 5'd1, 5'd2, 5'd7, 20'h0, 1'b1);
        idle(4);
        send_pair(OP_SUB, 5'd0, 5'd4, 5'd8, 20'h0, 1'b1, OP_ADD, 5'd4, 5'd4, 5'd10, 20'h0, 1'b1);
        idle(4);
        send_pair(OP_SLL, 5'd1, 5'd10, 5'd11, 20'h0, 1'b1, OP_SRL, 5'd9, 5'd8, 5'd12, 20'h0, 1'b1);
        send_pair(OP_AND, 5'd1, 5'd2, 5'd13, 20'h0, 1'b1, OP_OR, 5'd1, 5'd3, 5'd14, 20'h0, 1'b1);
        send_pair(OP_XOR, 5'd2, 5'd8, 5'd15, 20'h0, 1'b1, OP_SRL, 5'd2, 5'd4, 5'd16, 20'h0, 1'b1);
        send_pair(OP_SLT, 5'd8, 5'd4, 5'd17, 20'h0, 1'b1, OP_SLT, 5'd9, 5'd8, 5'd18, 20'h0, 1'b1);
        drain();
        test_end("opcodes");

        // reader at distance 1, 2, 3 pairs from its writer
        test_begin();
        for (d = 1; d <= 3; d++) begin
            send_pair(OP_LUI, 5'd0, 5'd0, 5'd20, 20'(d), 1'b1,
                      OP_LUI, 5'd0, 5'd0, 5'd21, 20'(d + 16), 1'b1);
            for (n = 0; n < d - 1; n++)
                send_pair(OP_AND, 5'd3, 5'd3, 5'd22, 20'h0, 1'b1,
                          OP_OR, 5'd1, 5'd0, 5'd23, 20'h0, 1'b1);
            send_pair(OP_ADD, 5'd20, 5'd21, 5'd24, 20'h0, 1'b1,
                      OP_SUB, 5'd21, 5'd20, 5'd25, 20'h0, 1'b1);
        end
        send_pair(OP_LUI, 5'd0, 5'd0, 5'd26, 20'h11111, 1'b1,
                  OP_LUI, 5'd0, 5'd0, 5'd26, 20'h22222, 1'b1);
        send_pair(OP_ADD, 5'd26, 5'd0, 5'd27, 20'h0, 1'b1, OP_XOR, 5'd26, 5'd1, 5'd28, 20'h0, 1'b1);
        send_pair(OP_ADD, 5'd26, 5'd4, 5'd27, 20'h0, 1'b1, OP_OR, 5'd26, 5'd3, 5'd28, 20'h0, 1'b1);
        drain();
        test_end("dependencies");

        test_begin();
        send_pair(OP_ADD, 5'd13, 5'd4, 5'd13, 20'h0, 1'b1, OP_OR, 5'd13, 5'd0, 5'd29, 20'h0, 1'b1);
        send_pair(OP_LUI, 5'd0, 5'd0, 5'd14, 20'haaaaa, 1'b1,
                  OP_LUI, 5'd0, 5'd0, 5'd14, 20'h55555, 1'b1);
        send_pair(OP_ADD, 5'd14, 5'd0, 5'd30, 20'h0, 1'b1,
                  OP_LUI, 5'd0, 5'd0, 5'd0, 20'hfffff, 1'b1);
        send_pair(OP_ADD, 5'd0, 5'd0, 5'd31, 20'h0, 1'b1, OP_OR, 5'd0, 5'd14, 5'd29, 20'h0, 1'b1);
        idle(4);
        send_pair(OP_ADD, 5'd0, 5'd14, 5'd15, 20'h0, 1'b1, OP_SUB, 5'd0, 5'd0, 5'd16, 20'h0, 1'b1);
        drain();
        test_end("pair rules and r0");

        // no credits back so CREDIT_MAX retire and the next three stay in the pipe
        test_begin();
        while (returned != spent)
            @(negedge clk);
        ret_mode = 0;
        n = spent;
        for (i = 0; i < CREDIT_MAX + 3; i++)
            send_pair(OP_ADD, 5'd16, 5'd4, 5'd16, 20'h0, 1'b1,
                      OP_XOR, 5'd16, 5'd1, 5'd17, 20'h0, 1'b1);
        for (i = 0; i < 30 && spent - n < CREDIT_MAX; i++)
            @(negedge clk);
        idle(5);
        if (spent - n != CREDIT_MAX) begin
            $display("%0d pairs retired without credit return, not %0d", spent - n, CREDIT_MAX);
            err_count++;
        end
        check_bit("in_ready", in_ready, 1'b0);
        check_bit("out_valid", out_valid, 1'b1);
        check_bit("busy", busy, 1'b1);
        ret_mode = 1;
        drain();
        test_end("back-pressure");

        test_begin();
        ret_mode = 2;
        for (i = 0; i < N_RANDOM; i++) begin
            ro0 = alu_op_e'($urandom_range(0, 8));
            ra0 = REG_AW'($urandom_range(0, 7));  // small range for many dependencies
            rb0 = REG_AW'($urandom_range(0, 7));
            rc0 = REG_AW'($urandom_range(0, 7));
            ri0 = 20'($urandom);
            rw0 = ($urandom_range(0, 3) != 0);
            ro1 = alu_op_e'($urandom_range(0, 8));
            ra1 = REG_AW'($urandom_range(0, 7));
            rb1 = REG_AW'($urandom_range(0, 7));
            rc1 = REG_AW'($urandom_range(0, 7));
            ri1 = 20'($urandom);
            rw1 = ($urandom_range(0, 3) != 0);
            send_pair(ro0, ra0, rb0, rc0, ri0, rw0, ro1, ra1, rb1, rc1, ri1, rw1);
            if ($urandom_range(0, 3) == 0)
                idle(1);
        end
        drain();
        test_end("random stream");

        $display("summary: %0d tests, %0d pairs checked, %0d errors",
                 test_no, checked, err_count);
        if (err_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
